/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= snes_sram_bridge_tb
RTL_TOP   ?= snes_sram_bridge
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* bench/bridge_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module bridge_checker (
  input wire       CLK2,
  input wire       snes_read,
  input wire [7:0] snes_data,
  input wire       snes_databus_oe,
  input wire       snes_databus_dir,
  input wire       mcu_rdy,
  input wire [7:0] mcu_rdata,
  input wire       rom_we,
  input wire       rom_bhe,
  input wire       rom_ble,
  input wire [7:0] exp_snes,
  input wire [7:0] exp_mcu,
  input wire       snes_chk_en,
  input wire       mcu_chk_en,
  input wire       oe_chk_en,
  input wire       lane_chk_en,
  input wire       lane_odd
);

  int    test_num = 0;
  int    test_errs = 0;
  int    total_errs = 0;
  int    passed = 0;
  string test_name = "";

  task automatic start_test(input string name);
    test_num++;
    test_errs = 0;
    test_name = name;
  endtask

  task automatic check_value(input string sig, input logic [23:0] got, input logic [23:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", sig, got, exp);
      test_errs++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    test_errs++;
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      passed++;
      $display("test %0d %s: passed", test_num, test_name);
    end else begin
      $display("test %0d %s: failed with %0d errors", test_num, test_name, test_errs);
    end
    total_errs += test_errs;
  endtask

  task automatic close_report(output int errs);
    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             test_num, passed, test_num - passed, total_errs);
    errs = total_errs;
  endtask

  ////////////////////////////////////////
  // SNES read data is still driven when the pin strobe rises
  always @(posedge snes_read) begin
    if (snes_chk_en) begin
      check_value("snes_data", snes_data, exp_snes);
      check_value("snes_databus_dir", snes_databus_dir, 1'b1);
      check_value("snes_databus_oe", snes_databus_oe, 1'b0);  // ROM region read
    end
  end

  always @(posedge mcu_rdy) begin
    @(negedge CLK2);  // mcu_rdata settles on the same edge
    if (mcu_chk_en) check_value("mcu_rdata", mcu_rdata, exp_mcu);
  end

  always @(negedge CLK2) begin
    if (oe_chk_en) check_value("snes_databus_oe", snes_databus_oe, 1'b1);
    if (lane_chk_en && !rom_we) begin
      check_value("rom_bhe", rom_bhe, lane_odd);   // enables are active low
      check_value("rom_ble", rom_ble, !lane_odd);
    end
  end

endmodule

`default_nettype wire

/* bench/snes_sram_bridge_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module snes_sram_bridge_tb;
  import bridge_pkg::*;

  localparam int N_RANDOM = 40;
  localparam int N_OPS    = 22 + 2 * N_RANDOM;
  localparam int CYCLE_NS = 20;

  wire         CLK2;
  wire         rst_n;
  wire [7:0]   snes_data;
  wire [15:0]  rom_data;
  wire [7:0]   ram_data;
  snes_addr_t  snes_addr;
  logic        snes_read;
  logic        snes_write;
  logic        snes_romsel;
  logic        snes_cpu_clk;
  byte_t       snes_drv;
  logic        snes_drv_en;
  logic        snes_databus_oe;
  logic        snes_databus_dir;
  logic [22:0] rom_addr;
  logic        rom_oe;
  logic        rom_we;
  logic        rom_bhe;
  logic        rom_ble;
  sram_addr_t  ram_addr;
  logic        ram_oe;
  logic        ram_we;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic        mcu_ramsel;
  psram_addr_t mcu_addr;
  byte_t       mcu_wdata;
  logic        mcu_rdy;
  byte_t       mcu_rdata;
  byte_t       exp_snes;
  byte_t       exp_mcu;
  logic        snes_chk_en;
  logic        mcu_chk_en;
  logic        oe_chk_en;
  logic        lane_chk_en;
  logic        lane_odd;
  int          errs;

  // memory models and the expected contents
  word_t       psram_mem [logic [22:0]];
  byte_t       sram_mem [0:(1 << 19) - 1];
  byte_t       psram_shadow [psram_addr_t];
  byte_t       sram_shadow [sram_addr_t];
  word_t       rom_rd_word;
  byte_t       ram_rd_byte;
  logic        rom_wr_armed = 1'b0;
  logic        ram_wr_armed = 1'b0;
  logic [22:0] rom_wr_addr;
  word_t       rom_wr_data;
  logic        rom_wr_bhe;
  logic        rom_wr_ble;
  sram_addr_t  ram_wr_addr;
  byte_t       ram_wr_data;

  tb_clock_gen u_clk (.CLK2(CLK2), .rst_n(rst_n));

  snes_sram_bridge u_dut (
    .CLK2(CLK2), .rst_n(rst_n),
    .snes_addr(snes_addr), .snes_read(snes_read), .snes_write(snes_write),
    .snes_romsel(snes_romsel), .snes_cpu_clk(snes_cpu_clk), .snes_data(snes_data),
    .snes_databus_oe(snes_databus_oe), .snes_databus_dir(snes_databus_dir),
    .rom_addr(rom_addr), .rom_data(rom_data), .rom_oe(rom_oe), .rom_we(rom_we),
    .rom_bhe(rom_bhe), .rom_ble(rom_ble),
    .ram_addr(ram_addr), .ram_data(ram_data), .ram_oe(ram_oe), .ram_we(ram_we),
    .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_ramsel(mcu_ramsel), .mcu_addr(mcu_addr),
    .mcu_wdata(mcu_wdata), .mcu_rdy(mcu_rdy), .mcu_rdata(mcu_rdata)
  );

  bridge_checker u_chk (
    .CLK2(CLK2), .snes_read(snes_read), .snes_data(snes_data),
    .snes_databus_oe(snes_databus_oe), .snes_databus_dir(snes_databus_dir),
    .mcu_rdy(mcu_rdy), .mcu_rdata(mcu_rdata),
    .rom_we(rom_we), .rom_bhe(rom_bhe), .rom_ble(rom_ble),
    .exp_snes(exp_snes), .exp_mcu(exp_mcu), .snes_chk_en(snes_chk_en),
    .mcu_chk_en(mcu_chk_en), .oe_chk_en(oe_chk_en), .lane_chk_en(lane_chk_en),
    .lane_odd(lane_odd)
  );

  function automatic word_t psram_fill(input logic [22:0] wa);
    return wa[15:0] ^ {wa[22:16], wa[22:16], 2'b10};
  endfunction

  function automatic byte_t sram_fill(input sram_addr_t a);
    return a[7:0] ^ a[15:8] ^ {5'b10100, a[18:16]};
  endfunction

  // LoROM: bank, then A14..A0, limited to the mapped ROM
  function automatic psram_addr_t map_snes(input snes_addr_t a);
    return {1'b0, a[23:16], a[14:0]} & ROM_MASK;
  endfunction

  function automatic byte_t psram_expect(input psram_addr_t a);
    word_t w;
    if (psram_shadow.exists(a)) return psram_shadow[a];
    w = psram_fill(a[23:1]);
    return a[0] ? w[7:0] : w[15:8];  // odd bytes sit on the low lane
  endfunction

  function automatic byte_t sram_expect(input sram_addr_t a);
    if (sram_shadow.exists(a)) return sram_shadow[a];
    return sram_fill(a);
  endfunction

  ////////////////////////////////////////
  // PSRAM and SRAM, written when WE goes back high
  assign rom_data  = rom_we ? rom_rd_word : 16'hzzzz;
  assign ram_data  = ram_we ? ram_rd_byte : 8'hzz;
  assign snes_data = snes_drv_en ? snes_drv : 8'hzz;

  always @(negedge CLK2) begin : mem_models
    word_t w;
    if (!rom_we) begin
      rom_wr_armed = 1'b1;
      rom_wr_addr  = rom_addr;
      rom_wr_data  = rom_data;
      rom_wr_bhe   = rom_bhe;
      rom_wr_ble   = rom_ble;
    end else if (rom_wr_armed) begin
      w = psram_mem.exists(rom_wr_addr) ? psram_mem[rom_wr_addr] : psram_fill(rom_wr_addr);
      if (!rom_wr_bhe) w[15:8] = rom_wr_data[15:8];
      if (!rom_wr_ble) w[7:0] = rom_wr_data[7:0];
      psram_mem[rom_wr_addr] = w;
      rom_wr_armed = 1'b0;
    end
    if (!ram_we) begin
      ram_wr_armed = 1'b1;
      ram_wr_addr  = ram_addr;
      ram_wr_data  = ram_data;
    end else if (ram_wr_armed) begin
      sram_mem[ram_wr_addr] = ram_wr_data;
      ram_wr_armed = 1'b0;
    end
    rom_rd_word = psram_mem.exists(rom_addr) ? psram_mem[rom_addr] : psram_fill(rom_addr);
    ram_rd_byte = sram_mem[ram_addr];
  end

  ////////////////////////////////////////
  // stimulus
  task automatic snes_cycle(input logic wr, input logic romsel, input snes_addr_t a,
                            input byte_t d);
    psram_addr_t m;
    m = map_snes(a);
    @(posedge CLK2);
    snes_addr    <= a;
    snes_romsel  <= romsel;
    snes_cpu_clk <= 1'b1;
    snes_drv     <= d;
    snes_drv_en  <= wr;
    if (!wr && !romsel) begin
      exp_snes    = psram_expect(m);
      snes_chk_en = 1'b1;
    end
    oe_chk_en = romsel;
    @(posedge CLK2);
    if (wr) snes_write <= 1'b0;
    else snes_read <= 1'b0;
    repeat (16) @(posedge CLK2);
    snes_write   <= 1'b1;
    snes_read    <= 1'b1;
    snes_cpu_clk <= 1'b0;  // cpu clock low ends the bus cycle
    @(posedge CLK2);
    snes_romsel <= 1'b1;
    snes_drv_en <= 1'b0;
    if (wr && !romsel) psram_shadow[m] = d;
    repeat (10) @(posedge CLK2);  // strobe history must refill
    snes_chk_en = 1'b0;
    oe_chk_en   = 1'b0;
  endtask

  task automatic mcu_op(input logic wr, input logic ramsel, input psram_addr_t a,
                        input byte_t d);
    int waited;
    waited = 0;
    if (!wr) begin
      exp_mcu    = ramsel ? sram_expect(a[18:0]) : psram_expect(a);
      mcu_chk_en = 1'b1;
    end
    @(posedge CLK2);
    mcu_rrq    <= !wr;
    mcu_wrq    <= wr;
    mcu_ramsel <= ramsel;
    mcu_addr   <= a;
    mcu_wdata  <= d;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    do begin
      @(negedge CLK2);
      waited++;
    end while (!mcu_rdy && waited < 400);
    if (!mcu_rdy) u_chk.note_failure("mcu request did not complete within 400 cycles");
    else if (wr && ramsel) sram_shadow[a[18:0]] = d;
    else if (wr) psram_shadow[a] = d;
    @(posedge CLK2);
    mcu_chk_en = 1'b0;
  endtask

  task automatic run_random_mix();
    logic        s_wr;
    logic        m_wr;
    logic        m_sel;
    snes_addr_t  sa;
    psram_addr_t ma;
    byte_t       sd;
    byte_t       md;
    int          d1;
    int          d2;
    for (int i = 0; i < N_RANDOM; i++) begin
      s_wr  = $urandom % 2;
      m_wr  = $urandom % 2;
      m_sel = $urandom % 2;
      sa    = {3'b000, 5'($urandom), 1'b1, 15'($urandom)};  // banks 00..1f
      ma    = m_sel ? {5'b0, 19'($urandom)} : {4'h2, 20'($urandom)};  // above the SNES range
      sd    = 8'($urandom);
      md    = 8'($urandom);
      d1    = $urandom % 12;
      d2    = $urandom % 12;
      fork
        begin
          repeat (d1) @(posedge CLK2);
          snes_cycle(s_wr, 1'b0, sa, sd);
        end
        begin
          repeat (d2) @(posedge CLK2);
          mcu_op(m_wr, m_sel, ma, md);
        end
      join
    end
  endtask

  initial begin
    void'($urandom(32'h1053_51ca));
    snes_addr = '0;
    snes_read = 1'b1;
    snes_write = 1'b1;
    snes_romsel = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_drv = '0;
    snes_drv_en = 1'b0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_ramsel = 1'b0;
    mcu_addr = '0;
    mcu_wdata = '0;
    exp_snes = '0;
    exp_mcu = '0;
    snes_chk_en = 1'b0;
    mcu_chk_en = 1'b0;
    oe_chk_en = 1'b0;
    lane_chk_en = 1'b0;
    lane_odd = 1'b0;
    for (int i = 0; i < (1 << 19); i++) sram_mem[i] = sram_fill(19'(i));

    wait (rst_n === 1'b1);
    @(negedge CLK2);
    u_chk.start_test("reset state");
    u_chk.check_value("mcu_rdy", mcu_rdy, 1'b1);
    u_chk.check_value("rom_we", rom_we, 1'b1);
    u_chk.check_value("ram_we", ram_we, 1'b1);
    u_chk.check_value("snes_databus_oe", snes_databus_oe, 1'b1);
    u_chk.check_value("snes_databus_dir", snes_databus_dir, 1'b0);  // data pins released
    u_chk.check_value("rom_oe", rom_oe, 1'b0);  // tied active
    u_chk.check_value("ram_oe", ram_oe, 1'b0);
    u_chk.finish_test();

    u_chk.start_test("psram byte lanes");
    lane_chk_en = 1'b1;
    lane_odd = 1'b0;
    mcu_op(1'b1, 1'b0, 24'h12_3456, 8'hc3);
    mcu_op(1'b0, 1'b0, 24'h12_3456, 8'h00);
    mcu_op(1'b0, 1'b0, 24'h12_3457, 8'h00);
    lane_odd = 1'b1;
    mcu_op(1'b1, 1'b0, 24'h12_3457, 8'h3c);
    mcu_op(1'b0, 1'b0, 24'h12_3457, 8'h00);
    mcu_op(1'b0, 1'b0, 24'h12_3456, 8'h00);
    lane_chk_en = 1'b0;
    u_chk.finish_test();

    u_chk.start_test("sram access");
    mcu_op(1'b1, 1'b1, 24'h05_a5a5, 8'h96);
    mcu_op(1'b1, 1'b1, 24'h07_0001, 8'h1e);
    mcu_op(1'b0, 1'b1, 24'h05_a5a5, 8'h00);
    mcu_op(1'b0, 1'b1, 24'h07_0001, 8'h00);
    mcu_op(1'b0, 1'b0, 24'h05_a5a5, 8'h00);  // psram untouched
    u_chk.finish_test();

    u_chk.start_test("snes read");
    snes_cycle(1'b0, 1'b0, 24'h00_8000, 8'h00);
    mcu_op(1'b1, 1'b0, map_snes(24'h02_9abd), 8'h5b);
    snes_cycle(1'b0, 1'b0, 24'h02_9abd, 8'h00);
    snes_cycle(1'b0, 1'b0, 24'h1f_fffe, 8'h00);
    snes_cycle(1'b0, 1'b0, 24'hc1_8000, 8'h00);  // bank folded by the ROM mask
    snes_cycle(1'b0, 1'b1, 24'h7e_1234, 8'h00);
    u_chk.finish_test();

    u_chk.start_test("snes write");
    snes_cycle(1'b1, 1'b0, 24'h03_8123, 8'h7e);
    mcu_op(1'b0, 1'b0, map_snes(24'h03_8123), 8'h00);
    snes_cycle(1'b1, 1'b0, 24'h03_8124, 8'ha1);
    mcu_op(1'b0, 1'b0, map_snes(24'h03_8124), 8'h00);
    snes_cycle(1'b0, 1'b0, 24'h03_8123, 8'h00);
    u_chk.finish_test();

    u_chk.start_test("random mix");
    run_random_mix();
    u_chk.finish_test();

    u_chk.close_report(errs);
    if (errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog, 400 cycles per operation
  initial begin
    #(N_OPS * 400 * CYCLE_NS);
    $display("watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic CLK2,
  output logic rst_n
);
  localparam int HALF_NS = 10;  // 20 ns period

  initial begin
    CLK2 = 1'b0;
    forever #HALF_NS CLK2 = ~CLK2;
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge CLK2);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* compile.f */
hdl/bridge_pkg.sv
hdl/snes_cycle_if.sv
hdl/mcu_req_if.sv
hdl/snes_bus_sync.sv
hdl/mcu_request.sv
hdl/mem_arbiter.sv
hdl/snes_sram_bridge.sv
bench/tb_clock_gen.sv
bench/bridge_checker.sv
bench/snes_sram_bridge_tb.sv

/* hdl/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

  typedef logic [23:0] snes_addr_t;
  typedef logic [23:0] psram_addr_t;  // byte address, bit 0 picks the lane
  typedef logic [18:0] sram_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [3:0]  delay_t;

  // mapped ROM limited to 4 Mbyte
  localparam psram_addr_t ROM_MASK = 24'h3f_ffff;

  localparam int SYNC_DEPTH = 8;  // strobe history in samples

  ////////////////////////////////////////
  // wait states, a count of N gives N+1 cycles
  localparam delay_t ROM_RD_WAIT  = 4'd4;
  localparam delay_t ROM_WR_WAIT1 = 4'd2;
  localparam delay_t ROM_WR_WAIT2 = 4'd3;
  localparam delay_t MCU_WAIT     = 4'd6;
  localparam delay_t MCU_TAIL     = 4'd2;

  typedef enum logic [4:0] {
    IDLE,
    SNES_RD_ADDR, SNES_RD_WAIT, SNES_RD_END,
    SNES_WR_ADDR, SNES_WR_WAIT1, SNES_WR_DATA, SNES_WR_WAIT2, SNES_WR_END,
    MCU_RD_ADDR, MCU_RD_WAIT, MCU_RD_TAIL, MCU_RD_END,
    MCU_WR_ADDR, MCU_WR_WAIT, MCU_WR_TAIL, MCU_WR_END
  } arb_state_t;

endpackage

`default_nettype wire

/* hdl/mcu_req_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface mcu_req_if ();
  import bridge_pkg::*;

  // request side
  logic        rd_pend;
  logic        wr_pend;
  logic        ramsel;   // 1 selects the SRAM
  psram_addr_t addr;
  byte_t       wdata;

  // service side
  logic        done;     // pulse on the END states
  byte_t       rdata;

  modport req (
    output rd_pend, wr_pend, ramsel, addr, wdata,
    input  done, rdata
  );

  modport svc (
    input  rd_pend, wr_pend, ramsel, addr, wdata,
    output done, rdata
  );

endinterface

`default_nettype wire

/* hdl/mcu_request.sv */
`timescale 1ns/1ns
`default_nettype none

module mcu_request (
  input  wire                          CLK2,
  input  wire                          rst_n,
  input  wire                          mcu_rrq,
  input  wire                          mcu_wrq,
  input  wire                          mcu_ramsel,
  input  wire bridge_pkg::psram_addr_t mcu_addr,
  input  wire bridge_pkg::byte_t       mcu_wdata,
  mcu_req_if.req                       req,
  output logic                         mcu_rdy,
  output bridge_pkg::byte_t            mcu_rdata
);

  logic take;

  // requests while busy are dropped
  assign take = mcu_rdy & (mcu_rrq | mcu_wrq);

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      req.rd_pend <= 1'b0;
      req.wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (take) begin
      req.rd_pend <= mcu_rrq;   // read wins a tie
      req.wr_pend <= ~mcu_rrq;
      mcu_rdy     <= 1'b0;
    end else if (req.done) begin
      req.rd_pend <= 1'b0;
      req.wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (take) begin
      req.addr   <= mcu_addr;
      req.wdata  <= mcu_wdata;
      req.ramsel <= mcu_ramsel;
    end
    // held for the MCU until the next read finishes
    if (req.done && req.rd_pend) begin
      mcu_rdata <= req.rdata;
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input  wire                     CLK2,
  input  wire                     rst_n,
  snes_cycle_if.dst               cyc,
  mcu_req_if.svc                  svc,
  output bridge_pkg::psram_addr_t rom_addr,
  input  wire bridge_pkg::word_t  rom_rdata,
  output bridge_pkg::word_t       rom_wdata,
  output logic                    rom_we,
  output logic                    rom_bhe,
  output logic                    rom_ble,
  output logic                    rom_drive,
  output bridge_pkg::sram_addr_t  ram_addr,
  input  wire bridge_pkg::byte_t  ram_rdata,
  output bridge_pkg::byte_t       ram_wdata,
  output logic                    ram_we,
  output bridge_pkg::byte_t       snes_rdata
);
  import bridge_pkg::*;

  arb_state_t  state;
  delay_t      delay;
  logic        need_snes_addr;  // SNES cycle still owed its address
  logic        mcu_busy;
  logic        snes_rd_go;
  logic        snes_wr_go;
  psram_addr_t addr_q;
  sram_addr_t  ram_addr_q;
  byte_t       wbyte_q;
  byte_t       lane_byte;

  assign snes_rd_go = cyc.rd_start & cyc.rom_hit;
  assign snes_wr_go = cyc.wr_start & cyc.rom_hit;
  assign mcu_busy   = state inside {MCU_RD_ADDR, MCU_RD_WAIT, MCU_RD_TAIL, MCU_RD_END,
                                    MCU_WR_ADDR, MCU_WR_WAIT, MCU_WR_TAIL, MCU_WR_END};

  // the MCU keeps the address for the whole of its access
  assign rom_addr  = (cyc.cpu_clk & need_snes_addr & ~mcu_busy) ? cyc.rom_addr : addr_q;
  assign lane_byte = rom_addr[0] ? rom_rdata[7:0] : rom_rdata[15:8];

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      need_snes_addr <= 1'b0;
    end else if (cyc.cycle_end) begin
      need_snes_addr <= 1'b1;
    end else if (state == SNES_RD_END || state == SNES_WR_END) begin
      need_snes_addr <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // access FSM, SNES starts override everything
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state <= IDLE;
      delay <= '0;
    end else if (snes_rd_go) begin
      state <= SNES_RD_ADDR;
    end else if (snes_wr_go) begin
      state <= SNES_WR_ADDR;
    end else begin
      delay <= delay - 4'd1;
      case (state)
        IDLE: begin
          if (svc.rd_pend) state <= MCU_RD_ADDR;
          else if (svc.wr_pend) state <= MCU_WR_ADDR;
        end
        SNES_RD_ADDR: begin
          state <= SNES_RD_WAIT;
          delay <= ROM_RD_WAIT;
        end
        SNES_RD_WAIT:  if (delay == '0) state <= SNES_RD_END;
        SNES_WR_ADDR: begin
          state <= SNES_WR_WAIT1;
          delay <= ROM_WR_WAIT1;
        end
        SNES_WR_WAIT1: if (delay == '0) state <= SNES_WR_DATA;
        SNES_WR_DATA: begin
          state <= SNES_WR_WAIT2;
          delay <= ROM_WR_WAIT2;
        end
        SNES_WR_WAIT2: if (delay == '0) state <= SNES_WR_END;
        MCU_RD_ADDR, MCU_WR_ADDR: begin
          state <= (state == MCU_RD_ADDR) ? MCU_RD_WAIT : MCU_WR_WAIT;
          delay <= MCU_WAIT;
        end
        MCU_RD_WAIT, MCU_WR_WAIT: begin
          if (delay == '0) begin
            state <= (state == MCU_RD_WAIT) ? MCU_RD_TAIL : MCU_WR_TAIL;
            delay <= MCU_TAIL;
          end
        end
        MCU_RD_TAIL:   if (delay == '0) state <= MCU_RD_END;
        MCU_WR_TAIL:   if (delay == '0) state <= MCU_WR_END;
        default:       state <= IDLE;  // the END states
      endcase
    end
  end

  // address, write byte and read latches
  always_ff @(posedge CLK2) begin
    if (snes_rd_go || snes_wr_go) begin
      addr_q <= cyc.rom_addr;
    end else begin
      case (state)
        IDLE: begin
          if (svc.rd_pend || svc.wr_pend) begin
            if (svc.ramsel) ram_addr_q <= svc.addr[18:0];
            else addr_q <= svc.addr;
            wbyte_q <= svc.wdata;
          end else if (cyc.rom_hit) begin
            addr_q <= cyc.rom_addr;
          end
        end
        SNES_RD_WAIT, SNES_RD_END: snes_rdata <= lane_byte;
        SNES_WR_DATA:              wbyte_q <= cyc.wdata;
        MCU_RD_WAIT:               svc.rdata <= svc.ramsel ? ram_rdata : lane_byte;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // strobes, OE stays active and WE overrides it
  always_comb begin
    rom_we = 1'b1;
    ram_we = 1'b1;
    if (state inside {SNES_WR_ADDR, SNES_WR_WAIT1, SNES_WR_DATA, SNES_WR_WAIT2, SNES_WR_END}) begin
      rom_we = 1'b0;
    end else if (state == MCU_WR_WAIT) begin
      if (svc.ramsel) ram_we = 1'b0;
      else rom_we = 1'b0;
    end
  end

  assign rom_drive = ~rom_we;
  assign rom_bhe   = rom_we ? 1'b0 : rom_addr[0];   // odd bytes on the low lane
  assign rom_ble   = rom_we ? 1'b0 : ~rom_addr[0];
  assign rom_wdata = rom_addr[0] ? {8'h00, wbyte_q} : {wbyte_q, 8'h00};
  assign ram_addr  = ram_addr_q;
  assign ram_wdata = wbyte_q;
  assign svc.done  = (state == MCU_RD_END) || (state == MCU_WR_END);

endmodule

`default_nettype wire

/* hdl/snes_bus_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module snes_bus_sync (
  input  wire                         CLK2,
  input  wire                         rst_n,
  input  wire bridge_pkg::snes_addr_t snes_addr,
  input  wire                         snes_read,
  input  wire                         snes_write,
  input  wire                         snes_romsel,
  input  wire                         snes_cpu_clk,
  input  wire bridge_pkg::byte_t      snes_data_in,
  snes_cycle_if.src                   cyc,
  output logic                        read_level,
  output logic                        write_level,
  output logic                        romsel_level
);
  import bridge_pkg::*;

  logic [SYNC_DEPTH-1:0] read_hist;
  logic [SYNC_DEPTH-1:0] write_hist;
  logic [SYNC_DEPTH-1:0] clk_hist;
  logic [2:0]            romsel_hist;
  logic                  read_q;
  logic                  write_q;
  logic                  clk_q;
  logic                  romsel_q;
  logic                  clk_level;
  snes_addr_t            addr_pipe [3];
  byte_t                 data_pipe [3];
  snes_addr_t            addr_s;

  // level moves only once two samples agree
  function automatic logic settle(input logic [1:0] taps, input logic prev);
    return (taps[1] == taps[0]) ? taps[0] : prev;
  endfunction

  // two low samples after a settled high history
  function automatic logic fell(input logic [SYNC_DEPTH-1:1] h);
    return (&h[SYNC_DEPTH-1:3]) && (h[2:1] == 2'b00);
  endfunction

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      read_hist   <= '1;
      write_hist  <= '1;
      clk_hist    <= '0;
      romsel_hist <= '1;
      read_q      <= 1'b1;
      write_q     <= 1'b1;
      clk_q       <= 1'b0;
      romsel_q    <= 1'b1;
    end else begin
      read_hist   <= {read_hist[SYNC_DEPTH-2:0], snes_read};
      write_hist  <= {write_hist[SYNC_DEPTH-2:0], snes_write};
      clk_hist    <= {clk_hist[SYNC_DEPTH-2:0], snes_cpu_clk};
      romsel_hist <= {romsel_hist[1:0], snes_romsel};
      read_q      <= read_level;
      write_q     <= write_level;
      clk_q       <= clk_level;
      romsel_q    <= romsel_level;
    end
  end

  // address and data ride along with the strobe taps
  always_ff @(posedge CLK2) begin
    addr_pipe <= '{snes_addr, addr_pipe[0], addr_pipe[1]};
    data_pipe <= '{snes_data_in, data_pipe[0], data_pipe[1]};
  end

  assign read_level   = settle(read_hist[2:1], read_q);
  assign write_level  = settle(write_hist[2:1], write_q);
  assign clk_level    = settle(clk_hist[2:1], clk_q);
  assign romsel_level = settle(romsel_hist[2:1], romsel_q);
  assign addr_s       = addr_pipe[2];

  ////////////////////////////////////////
  // events and LoROM decode
  assign cyc.rd_start  = fell(read_hist[SYNC_DEPTH-1:1]);
  assign cyc.wr_start  = fell(write_hist[SYNC_DEPTH-1:1]);
  assign cyc.cycle_end = fell(clk_hist[SYNC_DEPTH-1:1]);  // cpu clock falling
  assign cyc.cpu_clk   = clk_level;
  assign cyc.rom_hit   = ~romsel_level;
  assign cyc.rom_addr  = {1'b0, addr_s[23:16], addr_s[14:0]} & ROM_MASK;
  assign cyc.wdata     = data_pipe[2];

endmodule

`default_nettype wire

/* hdl/snes_cycle_if.sv */
`timescale 1ns/1ns
`default_nettype none

// filtered SNES bus events from the front end to the arbiter
interface snes_cycle_if ();
  import bridge_pkg::*;

  logic        rd_start;   // one-cycle events
  logic        wr_start;
  logic        cycle_end;
  logic        cpu_clk;    // filtered level
  logic        rom_hit;
  psram_addr_t rom_addr;   // LoROM mapped
  byte_t       wdata;

  modport src (
    output rd_start, wr_start, cycle_end, cpu_clk, rom_hit, rom_addr, wdata
  );

  modport dst (
    input rd_start, wr_start, cycle_end, cpu_clk, rom_hit, rom_addr, wdata
  );

endinterface

`default_nettype wire

/* hdl/snes_sram_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module snes_sram_bridge (
  input  wire                          CLK2,
  input  wire                          rst_n,
  input  wire bridge_pkg::snes_addr_t  snes_addr,
  input  wire                          snes_read,
  input  wire                          snes_write,
  input  wire                          snes_romsel,
  input  wire                          snes_cpu_clk,
  inout  wire bridge_pkg::byte_t       snes_data,
  output logic                         snes_databus_oe,
  output logic                         snes_databus_dir,
  output logic [22:0]                  rom_addr,      // word address
  inout  wire bridge_pkg::word_t       rom_data,
  output logic                         rom_oe,
  output logic                         rom_we,
  output logic                         rom_bhe,
  output logic                         rom_ble,
  output bridge_pkg::sram_addr_t       ram_addr,
  inout  wire bridge_pkg::byte_t       ram_data,
  output logic                         ram_oe,
  output logic                         ram_we,
  input  wire                          mcu_rrq,
  input  wire                          mcu_wrq,
  input  wire                          mcu_ramsel,
  input  wire bridge_pkg::psram_addr_t mcu_addr,
  input  wire bridge_pkg::byte_t       mcu_wdata,
  output logic                         mcu_rdy,
  output bridge_pkg::byte_t            mcu_rdata
);
  import bridge_pkg::*;

  psram_addr_t rom_byte_addr;
  word_t       rom_wdata;
  byte_t       ram_wdata;
  byte_t       snes_rdata;
  logic        rom_drive;
  logic        read_level;
  logic        write_level;
  logic        romsel_level;

  snes_cycle_if cyc_if ();
  mcu_req_if    req_if ();

  snes_bus_sync u_sync (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_addr    (snes_addr),
    .snes_read    (snes_read),
    .snes_write   (snes_write),
    .snes_romsel  (snes_romsel),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_data_in (snes_data),
    .cyc          (cyc_if.src),
    .read_level   (read_level),
    .write_level  (write_level),
    .romsel_level (romsel_level)
  );

  mcu_request u_mcu (
    .CLK2       (CLK2),
    .rst_n      (rst_n),
    .mcu_rrq    (mcu_rrq),
    .mcu_wrq    (mcu_wrq),
    .mcu_ramsel (mcu_ramsel),
    .mcu_addr   (mcu_addr),
    .mcu_wdata  (mcu_wdata),
    .req        (req_if.req),
    .mcu_rdy    (mcu_rdy),
    .mcu_rdata  (mcu_rdata)
  );

  mem_arbiter u_arb (
    .CLK2       (CLK2),
    .rst_n      (rst_n),
    .cyc        (cyc_if.dst),
    .svc        (req_if.svc),
    .rom_addr   (rom_byte_addr),
    .rom_rdata  (rom_data),
    .rom_wdata  (rom_wdata),
    .rom_we     (rom_we),
    .rom_bhe    (rom_bhe),
    .rom_ble    (rom_ble),
    .rom_drive  (rom_drive),
    .ram_addr   (ram_addr),
    .ram_rdata  (ram_data),
    .ram_wdata  (ram_wdata),
    .ram_we     (ram_we),
    .snes_rdata (snes_rdata)
  );

  ////////////////////////////////////////
  // pins and bus buffers
  assign rom_addr  = rom_byte_addr[23:1];
  assign rom_data  = rom_drive ? rom_wdata : 'z;
  assign ram_data  = ram_we ? 'z : ram_wdata;
  assign snes_data = read_level ? 'z : snes_rdata;
  assign rom_oe    = 1'b0;
  assign ram_oe    = 1'b0;

  assign snes_databus_dir = ~read_level;
  // transceiver opens only for ROM region cycles
  assign snes_databus_oe  = romsel_level | (read_level & write_level);

endmodule

`default_nettype wire
